// ==== ex_top.f ====
+incdir+rtl
rtl/ex_pkg.sv
rtl/bypass_unit.sv
rtl/alu.sv
rtl/mul_unit.sv
rtl/ex_stage.sv
rtl/ex_top.sv
testbench/tb_clock.sv
testbench/ex_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator and run it.
# The exit status is the simulator's, nonzero when a check fails.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module ex_top_tb -Mdir obj_dir -o ex_top_tb_sim -f ex_top.f; then
  echo "verilator build did not complete"
  exit 1
fi

if ! ./obj_dir/ex_top_tb_sim; then
  echo "simulation returned an error status"
  exit 1
fi

exit 0

// ==== testbench/ex_top_tb.sv ====
`timescale 1ns/1ps

module ex_top_tb;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_IDLE = 3;
  localparam int NUM_RANDOM = 400;
  localparam int NUM_DIRECTED = 34;
  // one cycle per instruction, plus slack for reset and drain
  localparam int NUM_CYCLES = NUM_IDLE + NUM_RANDOM + NUM_DIRECTED + 50;

  logic            clk;
  logic            rst;
  ex_pkg::id_ex_t  id_ex;
  ex_pkg::ex_mem_t ex_mem;
  logic            ex_load_flag;

  // reference state, mirrors the EX/MEM register and HI/LO
  ex_pkg::ex_mem_t ref_prev = '0;
  ex_pkg::data_t   ref_hi = '0;
  ex_pkg::data_t   ref_lo = '0;
  ex_pkg::ex_mem_t exp_mem = '0;
  logic            exp_load = 1'b0;
  logic            checking = 1'b0;
  logic [31:0]     lfsr = 32'h0ea83d23;
  ex_pkg::addr_t   pc_next = 32'h0040_0000;
  string           test_name = "none";

  tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_inst (.clk(clk));

  ex_top ex_top_inst (
    .clk          (clk),
    .rst          (rst),
    .id_ex        (id_ex),
    .ex_mem       (ex_mem),
    .ex_load_flag (ex_load_flag)
  );

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // expected EX/MEM contents for one instruction
  function automatic ex_pkg::ex_mem_t exec_ref(input ex_pkg::id_ex_t in);
    ex_pkg::ex_mem_t out;
    ex_pkg::data_t   a;
    ex_pkg::data_t   b;
    ex_pkg::data_t   r;
    longint          wide;
    logic [63:0]     prod;
    logic            ovf;
    logic            fwd;
    fwd = ref_prev.valid && ref_prev.reg_write_en && (ref_prev.reg_write_addr != 5'd0);
    a = (fwd && ref_prev.reg_write_addr == in.rs_addr) ? ref_prev.result : in.operand_1;
    b = (fwd && ref_prev.reg_write_addr == in.rt_addr) ? ref_prev.result : in.operand_2;
    ovf = 1'b0;
    prod = '0;
    case (in.op)
      ex_pkg::ALU_OR,
      ex_pkg::ALU_JALR:  r = a | b;
      ex_pkg::ALU_AND:   r = a & b;
      ex_pkg::ALU_XOR:   r = a ^ b;
      ex_pkg::ALU_SLT:   r = ex_pkg::data_t'($signed(a) < $signed(b));
      ex_pkg::ALU_SLTU:  r = ex_pkg::data_t'(a < b);
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_ADDU,
      ex_pkg::ALU_ADDI: begin
        r = a + b;
        wide = longint'($signed(a)) + longint'($signed(b));
        // true sum does not fit in one signed word
        ovf = (in.op != ex_pkg::ALU_ADDU) && (wide != longint'($signed(r)));
      end
      ex_pkg::ALU_SUB,
      ex_pkg::ALU_SUBU: begin
        r = a - b;
        wide = longint'($signed(a)) - longint'($signed(b));
        ovf = (in.op == ex_pkg::ALU_SUB) && (wide != longint'($signed(r)));
      end
      ex_pkg::ALU_MULT: begin
        prod = longint'($signed(a)) * longint'($signed(b));
        r = prod[31:0];
      end
      ex_pkg::ALU_MULTU: begin
        prod = {32'd0, a} * {32'd0, b};
        r = prod[31:0];
      end
      ex_pkg::ALU_MFHI:  r = ref_hi;
      ex_pkg::ALU_MFLO:  r = ref_lo;
      ex_pkg::ALU_SLL:   r = b << in.shamt;
      ex_pkg::ALU_SLLV:  r = b << a[4:0];
      ex_pkg::ALU_SRLV:  r = b >> a[4:0];
      ex_pkg::ALU_SRAV:  r = ex_pkg::data_t'($signed(b) >>> a[4:0]);
      default:           r = '0;
    endcase
    if (in.valid && (in.op == ex_pkg::ALU_MULT || in.op == ex_pkg::ALU_MULTU)) begin
      {ref_hi, ref_lo} = prod;
    end
    out.valid = in.valid;
    out.result = r;
    out.mem = in.mem;
    out.reg_write_en = in.valid && in.reg_write_en && !in.mem.write && !ovf;
    out.reg_write_addr = in.reg_write_addr;
    out.pc = in.pc;
    ref_prev = out;
    return out;
  endfunction

  function automatic ex_pkg::id_ex_t make_instr(input ex_pkg::alu_op_t op,
      input ex_pkg::reg_addr_t rs, input ex_pkg::reg_addr_t rt,
      input ex_pkg::data_t a, input ex_pkg::data_t b, input ex_pkg::reg_addr_t rd);
    ex_pkg::id_ex_t t;
    t = '0;
    t.valid = 1'b1;
    t.op = op;
    t.rs_addr = rs;
    t.rt_addr = rt;
    t.operand_1 = a;
    t.operand_2 = b;
    t.reg_write_en = 1'b1;
    t.reg_write_addr = rd;
    t.pc = pc_next;
    pc_next = pc_next + 32'd4;
    return t;
  endfunction

  // small register range so that forwarding hits often
  function automatic ex_pkg::id_ex_t rand_instr();
    ex_pkg::id_ex_t t;
    t.valid = (rand_bits(3) != 32'd0);
    t.op = ex_pkg::alu_op_t'(5'(rand_bits(5) % 32'd20));
    t.shamt = ex_pkg::shamt_t'(rand_bits(5));
    t.rs_addr = ex_pkg::reg_addr_t'(rand_bits(3));
    t.rt_addr = ex_pkg::reg_addr_t'(rand_bits(3));
    t.operand_1 = rand_bits(32);
    t.operand_2 = rand_bits(32);
    t.mem.read = (rand_bits(3) == 32'd0);
    t.mem.write = (rand_bits(3) == 32'd0);
    t.mem.sign = rand_bits(1) != 32'd0;
    t.mem.sel = ex_pkg::mem_sel_t'(rand_bits(4));
    t.mem.write_data = rand_bits(32);
    t.reg_write_en = (rand_bits(3) != 32'd0);
    t.reg_write_addr = ex_pkg::reg_addr_t'(rand_bits(3));
    t.pc = rand_bits(32);
    return t;
  endfunction

  task automatic stop_failed();
    $display("sim failed");
    $fatal(1, "run stopped at the first mismatch");
  endtask

  task automatic check_data(input string what, input ex_pkg::data_t exp, input ex_pkg::data_t act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_reg_addr(input string what, input ex_pkg::reg_addr_t exp,
      input ex_pkg::reg_addr_t act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_addr(input string what, input ex_pkg::addr_t exp, input ex_pkg::addr_t act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_mem(input string what, input ex_pkg::mem_ctrl_t exp,
      input ex_pkg::mem_ctrl_t act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      stop_failed();
    end
  endtask

  // present one instruction on the falling edge and predict its outcome
  task automatic drive(input ex_pkg::id_ex_t instr, input string name);
    @(negedge clk);
    id_ex = instr;
    test_name = name;
    exp_mem = exec_ref(instr);
    exp_load = instr.valid && instr.mem.read;
    checking = 1'b1;
  endtask

  task automatic run(input string name, input ex_pkg::alu_op_t op,
      input ex_pkg::reg_addr_t rs, input ex_pkg::reg_addr_t rt,
      input ex_pkg::data_t a, input ex_pkg::data_t b, input ex_pkg::reg_addr_t rd);
    drive(make_instr(op, rs, rt, a, b, rd), name);
  endtask

  // outputs settle just after the rising edge
  always begin
    @(posedge clk);
    #1;
    if (checking) begin
      check_flag("valid", exp_mem.valid, ex_mem.valid);
      check_data("result", exp_mem.result, ex_mem.result);
      check_mem("mem", exp_mem.mem, ex_mem.mem);
      check_flag("reg_write_en", exp_mem.reg_write_en, ex_mem.reg_write_en);
      check_reg_addr("reg_write_addr", exp_mem.reg_write_addr, ex_mem.reg_write_addr);
      check_addr("pc", exp_mem.pc, ex_mem.pc);
      check_flag("ex_load_flag", exp_load, ex_load_flag);
    end
  end

  initial begin
    #(CLK_PERIOD * NUM_CYCLES);
    $display("timeout after %0d cycles, the test did not finish", NUM_CYCLES);
    $display("sim failed");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    ex_pkg::id_ex_t t;
    rst = 1'b1;
    id_ex = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_name = "reset";
    check_flag("valid", 1'b0, ex_mem.valid);
    check_flag("reg_write_en", 1'b0, ex_mem.reg_write_en);
    check_flag("mem.read", 1'b0, ex_mem.mem.read);
    check_flag("mem.write", 1'b0, ex_mem.mem.write);
    // bubbles reading HI before any multiply
    t = make_instr(ex_pkg::ALU_MFHI, 5'd0, 5'd0, 32'h1234_5678, 32'h9abc_def0, 5'd3);
    t.valid = 1'b0;
    repeat (NUM_IDLE) drive(t, "idle_mfhi");
    for (int i = 0; i < NUM_RANDOM; i++) begin
      drive(rand_instr(), $sformatf("random_%0d", i));
    end
    run("srav_neg_0", ex_pkg::ALU_SRAV, 5'd0, 5'd0, 32'd0, 32'h8000_0010, 5'd1);
    run("srav_neg_31", ex_pkg::ALU_SRAV, 5'd0, 5'd0, 32'd31, 32'h8000_0000, 5'd1);
    run("srav_neg_4", ex_pkg::ALU_SRAV, 5'd0, 5'd0, 32'hffff_ffe4, 32'hf000_0f00, 5'd1);
    run("srlv_31", ex_pkg::ALU_SRLV, 5'd0, 5'd0, 32'd31, 32'hffff_ffff, 5'd2);
    run("sllv_0", ex_pkg::ALU_SLLV, 5'd0, 5'd0, 32'd32, 32'h1357_9bdf, 5'd2);
    t = make_instr(ex_pkg::ALU_SLL, 5'd0, 5'd0, 32'd0, 32'h0000_0003, 5'd2);
    t.shamt = 5'd31;
    drive(t, "sll_31");
    t.shamt = 5'd0;
    drive(t, "sll_0");
    run("slt_neg", ex_pkg::ALU_SLT, 5'd0, 5'd0, 32'hffff_ffff, 32'd1, 5'd3);
    run("sltu_neg", ex_pkg::ALU_SLTU, 5'd0, 5'd0, 32'hffff_ffff, 32'd1, 5'd3);
    // same values, trapping and wrapping forms
    run("add_ovf", ex_pkg::ALU_ADD, 5'd0, 5'd0, 32'h7fff_ffff, 32'd1, 5'd4);
    run("addu_wrap", ex_pkg::ALU_ADDU, 5'd0, 5'd0, 32'h7fff_ffff, 32'd1, 5'd4);
    run("addi_ovf", ex_pkg::ALU_ADDI, 5'd0, 5'd0, 32'h7fff_ffff, 32'd1, 5'd4);
    run("sub_ovf", ex_pkg::ALU_SUB, 5'd0, 5'd0, 32'h8000_0000, 32'd1, 5'd4);
    run("subu_wrap", ex_pkg::ALU_SUBU, 5'd0, 5'd0, 32'h8000_0000, 32'd1, 5'd4);
    t = make_instr(ex_pkg::ALU_ADD, 5'd0, 5'd0, 32'd5, 32'd6, 5'd4);
    t.mem.write = 1'b1;
    t.mem.sel = 4'hf;
    t.mem.write_data = 32'hcafe_f00d;
    drive(t, "store");
    run("mult_mixed", ex_pkg::ALU_MULT, 5'd0, 5'd0, 32'hffff_fffd, 32'd7, 5'd0);
    run("mfhi_mult", ex_pkg::ALU_MFHI, 5'd0, 5'd0, 32'd0, 32'd0, 5'd8);
    run("mflo_mult", ex_pkg::ALU_MFLO, 5'd0, 5'd0, 32'd0, 32'd0, 5'd8);
    run("multu_mixed", ex_pkg::ALU_MULTU, 5'd0, 5'd0, 32'hffff_fffd, 32'd7, 5'd0);
    run("mfhi_multu", ex_pkg::ALU_MFHI, 5'd0, 5'd0, 32'd0, 32'd0, 5'd8);
    run("mflo_multu", ex_pkg::ALU_MFLO, 5'd0, 5'd0, 32'd0, 32'd0, 5'd8);
    run("mult_min", ex_pkg::ALU_MULT, 5'd0, 5'd0, 32'h8000_0000, 32'h8000_0000, 5'd0);
    run("mfhi_min", ex_pkg::ALU_MFHI, 5'd0, 5'd0, 32'd0, 32'd0, 5'd8);
    // back to back dependencies
    run("fwd_src", ex_pkg::ALU_ADDU, 5'd0, 5'd0, 32'd10, 32'd20, 5'd5);
    run("fwd_rs", ex_pkg::ALU_OR, 5'd5, 5'd0, 32'd0, 32'h100, 5'd6);
    run("fwd_rt", ex_pkg::ALU_SUBU, 5'd0, 5'd6, 32'd1000, 32'd0, 5'd7);
    run("r0_src", ex_pkg::ALU_ADDU, 5'd0, 5'd0, 32'd1, 32'd2, 5'd0);
    run("r0_no_fwd", ex_pkg::ALU_OR, 5'd0, 5'd0, 32'h55, 32'haa, 5'd9);
    run("ovf_src", ex_pkg::ALU_ADD, 5'd0, 5'd0, 32'h7fff_ffff, 32'h7fff_ffff, 5'd6);
    run("ovf_no_fwd", ex_pkg::ALU_OR, 5'd6, 5'd6, 32'h1, 32'h2, 5'd9);
    t = make_instr(ex_pkg::ALU_ADDU, 5'd0, 5'd0, 32'd3, 32'd4, 5'd7);
    t.reg_write_en = 1'b0;
    drive(t, "nowrite_src");
    run("nowrite_no_fwd", ex_pkg::ALU_OR, 5'd7, 5'd7, 32'h10, 32'h20, 5'd9);
    t = make_instr(ex_pkg::ALU_ADDU, 5'd0, 5'd0, 32'h1000, 32'h24, 5'd10);
    t.mem.read = 1'b1;
    t.mem.sign = 1'b1;
    t.mem.sel = 4'h3;
    drive(t, "load");
    t.valid = 1'b0;
    t.mem = '0;
    drive(t, "drain");
    @(posedge clk);
    #2;
    $display("sim passed");
    $finish;
  end

endmodule

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

// ==== rtl/ex_top.sv ====
`timescale 1ns/1ps

module ex_top (
  input  logic            clk,
  input  logic            rst,
  input  ex_pkg::id_ex_t  id_ex,
  output ex_pkg::ex_mem_t ex_mem,
  output logic            ex_load_flag
);

  ex_pkg::id_ex_t id_ex_fwd;

  // operands corrected from the instruction one ahead
  bypass_unit bypass_unit_inst (
    .id_ex     (id_ex),
    .ex_mem    (ex_mem),
    .id_ex_fwd (id_ex_fwd)
  );

  ex_stage ex_stage_inst (
    .clk    (clk),
    .rst    (rst),
    .id_ex  (id_ex_fwd),
    .ex_mem (ex_mem)
  );

  // load in EX, decode stalls on this
  assign ex_load_flag = id_ex.valid && id_ex.mem.read;

endmodule

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
  input  logic            clk,
  input  logic            rst,
  input  ex_pkg::id_ex_t  id_ex,
  output ex_pkg::ex_mem_t ex_mem
);

  ex_pkg::data_t   alu_result;
  ex_pkg::data_t   hilo_read;
  ex_pkg::data_t   result;
  logic            overflow;
  ex_pkg::ex_mem_t ex_mem_next;

  alu alu_inst (
    .op        (id_ex.op),
    .shamt     (id_ex.shamt),
    .operand_1 (id_ex.operand_1),
    .operand_2 (id_ex.operand_2),
    .result    (alu_result),
    .overflow  (overflow)
  );

  mul_unit mul_unit_inst (
    .clk       (clk),
    .rst       (rst),
    .valid     (id_ex.valid),
    .op        (id_ex.op),
    .operand_1 (id_ex.operand_1),
    .operand_2 (id_ex.operand_2),
    .hilo_read (hilo_read)
  );

  // result mux
  always_comb begin
    case (id_ex.op)
      ex_pkg::ALU_MFHI,
      ex_pkg::ALU_MFLO,
      ex_pkg::ALU_MULT,
      ex_pkg::ALU_MULTU: result = hilo_read;
      default:           result = alu_result;
    endcase
  end

  always_comb begin
    ex_mem_next.valid          = id_ex.valid;
    ex_mem_next.result         = result;
    ex_mem_next.mem            = id_ex.mem;
    // no write for a bubble, a store, or a trapping add/sub
    ex_mem_next.reg_write_en   = id_ex.valid && id_ex.reg_write_en &&
                                 !id_ex.mem.write && !overflow;
    ex_mem_next.reg_write_addr = id_ex.reg_write_addr;
    ex_mem_next.pc             = id_ex.pc;
  end

  // EX/MEM register
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem <= '0;
    end else begin
      ex_mem <= ex_mem_next;
    end
  end

endmodule

// ==== rtl/mul_unit.sv ====
`timescale 1ns/1ps

`include "ex_macros.svh"

module mul_unit (
  input  logic            clk,
  input  logic            rst,
  input  logic            valid,
  input  ex_pkg::alu_op_t op,
  input  ex_pkg::data_t   operand_1,
  input  ex_pkg::data_t   operand_2,
  output ex_pkg::data_t   hilo_read
);

  localparam int MSB = `EX_DATA_W - 1;

  logic           is_mul;
  logic           mul_signed;
  logic           neg_product;
  ex_pkg::data_t  mag_1;
  ex_pkg::data_t  mag_2;
  ex_pkg::dword_t product_mag;
  ex_pkg::dword_t product;
  ex_pkg::data_t  hi;
  ex_pkg::data_t  lo;

  assign is_mul     = (op == ex_pkg::ALU_MULT) || (op == ex_pkg::ALU_MULTU);
  assign mul_signed = (op == ex_pkg::ALU_MULT) ? `EX_MUL_SIGNED : `EX_MUL_UNSIGNED;

  // unsigned magnitudes, sign fixed up after the multiply
  assign mag_1 = (mul_signed && operand_1[MSB]) ? (~operand_1 + 1'b1) : operand_1;
  assign mag_2 = (mul_signed && operand_2[MSB]) ? (~operand_2 + 1'b1) : operand_2;

  assign product_mag = ex_pkg::dword_t'(mag_1) * ex_pkg::dword_t'(mag_2);

  assign neg_product = mul_signed && (operand_1[MSB] ^ operand_2[MSB]);
  assign product     = neg_product ? (~product_mag + 1'b1) : product_mag;

  always_ff @(posedge clk) begin
    if (rst) begin
      hi <= '0;
      lo <= '0;
    end else if (valid && is_mul) begin
      hi <= product[2*`EX_DATA_W-1:`EX_DATA_W];
      lo <= product[`EX_DATA_W-1:0];
    end
  end

  // a multiply itself also returns its low word here
  always_comb begin
    case (op)
      ex_pkg::ALU_MFHI:  hilo_read = hi;
      ex_pkg::ALU_MFLO:  hilo_read = lo;
      ex_pkg::ALU_MULT,
      ex_pkg::ALU_MULTU: hilo_read = product[`EX_DATA_W-1:0];
      default:           hilo_read = '0;
    endcase
  end

endmodule

// ==== rtl/alu.sv ====
`timescale 1ns/1ps

`include "ex_macros.svh"

module alu (
  input  ex_pkg::alu_op_t op,
  input  ex_pkg::shamt_t  shamt,
  input  ex_pkg::data_t   operand_1,
  input  ex_pkg::data_t   operand_2,
  output ex_pkg::data_t   result,
  output logic            overflow
);

  localparam int MSB = `EX_DATA_W - 1;

  logic           is_sub;
  logic           is_signed_arith;
  logic           eff_sign_2;
  logic           lt_signed;
  logic           lt_unsigned;
  ex_pkg::data_t  operand_2_mux;
  ex_pkg::data_t  sum;
  ex_pkg::shamt_t shift_var;

  // subtract and the signed compare share the adder
  assign is_sub = (op == ex_pkg::ALU_SUB) || (op == ex_pkg::ALU_SUBU) ||
                  (op == ex_pkg::ALU_SLT);

  assign operand_2_mux = is_sub ? (~operand_2 + 1'b1) : operand_2;
  assign sum           = operand_1 + operand_2_mux;

  // sign of the second operand as the adder sees it
  // taken from operand_2 so that negating the most negative value still works
  assign eff_sign_2 = is_sub ? ~operand_2[MSB] : operand_2[MSB];

  assign is_signed_arith = (op == ex_pkg::ALU_ADD) || (op == ex_pkg::ALU_ADDI) ||
                           (op == ex_pkg::ALU_SUB);

  // same input signs, different output sign
  assign overflow = is_signed_arith && (operand_1[MSB] == eff_sign_2) &&
                    (sum[MSB] != operand_1[MSB]);

  // negative vs positive, or same signs and a negative difference
  assign lt_signed = (operand_1[MSB] && !operand_2[MSB]) ||
                     ((operand_1[MSB] == operand_2[MSB]) && sum[MSB]);
  assign lt_unsigned = operand_1 < operand_2;

  assign shift_var = operand_1[`EX_SHAMT_W-1:0];

  always_comb begin
    case (op)
      // link value is already in an operand
      ex_pkg::ALU_OR,
      ex_pkg::ALU_JALR: result = operand_1 | operand_2;
      ex_pkg::ALU_AND:  result = operand_1 & operand_2;
      ex_pkg::ALU_XOR:  result = operand_1 ^ operand_2;
      ex_pkg::ALU_SLT:  result = {{(`EX_DATA_W-1){1'b0}}, lt_signed};
      ex_pkg::ALU_SLTU: result = {{(`EX_DATA_W-1){1'b0}}, lt_unsigned};
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_ADDU,
      ex_pkg::ALU_ADDI,
      ex_pkg::ALU_SUB,
      ex_pkg::ALU_SUBU: result = sum;
      ex_pkg::ALU_SLL:  result = operand_2 << shamt;
      ex_pkg::ALU_SLLV: result = operand_2 << shift_var;
      ex_pkg::ALU_SRLV: result = operand_2 >> shift_var;
      ex_pkg::ALU_SRAV: result = ex_pkg::data_t'($signed(operand_2) >>> shift_var);
      // multiply and HI/LO moves come from mul_unit
      default:          result = '0;
    endcase
  end

endmodule

// ==== rtl/bypass_unit.sv ====
`timescale 1ns/1ps

module bypass_unit (
  input  ex_pkg::id_ex_t  id_ex,
  input  ex_pkg::ex_mem_t ex_mem,
  output ex_pkg::id_ex_t  id_ex_fwd
);

  logic fwd_ok;
  logic fwd_rs;
  logic fwd_rt;

  // previous instruction really writes a register other than r0
  assign fwd_ok = ex_mem.valid && ex_mem.reg_write_en &&
                  (ex_mem.reg_write_addr != '0);

  // immediates and link values come in with a zero source index
  assign fwd_rs = fwd_ok && (ex_mem.reg_write_addr == id_ex.rs_addr);
  assign fwd_rt = fwd_ok && (ex_mem.reg_write_addr == id_ex.rt_addr);

  always_comb begin
    id_ex_fwd = id_ex;
    if (fwd_rs) begin
      id_ex_fwd.operand_1 = ex_mem.result;
    end
    if (fwd_rt) begin
      id_ex_fwd.operand_2 = ex_mem.result;
    end
  end

endmodule

// ==== rtl/ex_pkg.sv ====
`include "ex_macros.svh"

package ex_pkg;

  // width types
  typedef logic [`EX_DATA_W-1:0]     data_t;
  typedef logic [`EX_ADDR_W-1:0]     addr_t;
  typedef logic [`EX_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`EX_SHAMT_W-1:0]    shamt_t;
  typedef logic [`EX_MEM_SEL_W-1:0]  mem_sel_t;
  typedef logic [2*`EX_DATA_W-1:0]   dword_t;

  // operations as produced by decode
  typedef enum logic [4:0] {
    ALU_NOP   = 5'd0,
    ALU_OR    = 5'd1,
    ALU_AND   = 5'd2,
    ALU_XOR   = 5'd3,
    ALU_JALR  = 5'd4,
    ALU_SLT   = 5'd5,
    ALU_SLTU  = 5'd6,
    ALU_ADD   = 5'd7,
    ALU_ADDU  = 5'd8,
    ALU_ADDI  = 5'd9,
    ALU_SUB   = 5'd10,
    ALU_SUBU  = 5'd11,
    ALU_MULT  = 5'd12,
    ALU_MULTU = 5'd13,
    ALU_MFHI  = 5'd14,
    ALU_MFLO  = 5'd15,
    ALU_SLL   = 5'd16,
    ALU_SLLV  = 5'd17,
    ALU_SRLV  = 5'd18,
    ALU_SRAV  = 5'd19
  } alu_op_t;

  // load/store controls, carried to MEM as is
  typedef struct packed {
    logic     read;
    logic     write;
    logic     sign;
    mem_sel_t sel;
    data_t    write_data;
  } mem_ctrl_t;

  // decoded instruction entering EX
  typedef struct packed {
    logic      valid;
    alu_op_t   op;
    shamt_t    shamt;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    data_t     operand_1;
    data_t     operand_2;
    mem_ctrl_t mem;
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    addr_t     pc;
  } id_ex_t;

  // EX/MEM pipeline register contents
  typedef struct packed {
    logic      valid;
    data_t     result;
    mem_ctrl_t mem;
    logic      reg_write_en;
    reg_addr_t reg_write_addr;
    addr_t     pc;
  } ex_mem_t;

endpackage

// ==== rtl/ex_macros.svh ====
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// data word width
`define EX_DATA_W 32

// program counter width
`define EX_ADDR_W 32

// register file index
`define EX_REG_ADDR_W 5

// shift amount, also the low bits of a variable shift operand
`define EX_SHAMT_W 5

// one select bit per byte lane
`define EX_MEM_SEL_W 4

// multiply signedness selector
`define EX_MUL_SIGNED   1'b1
`define EX_MUL_UNSIGNED 1'b0

`endif
